/* design/sa_defines.svh */
`ifndef SA_DEFINES_SVH
`define SA_DEFINES_SVH

`define SA_RBUS_ADDR_BITS 16
`define SA_RBUS_DATA_BITS 32
`define SA_LOCL_ADDR_BITS 8
`define SA_N_CHANNELS 64
`define SA_IDX_BITS 6
`define SA_COUNT_BITS 50
`define SA_N_EVENTS 16
`define SA_REVISION 8'h2a

// byte offsets inside the slice window.
`define SA_REVISION_ADDR          8'h00
`define SA_SPARE_ADDR             8'h04
`define SA_GLOBAL_CTRL_ADDR       8'h08
`define SA_CTRL_IA_WDATA_ADDR     8'h0C
`define SA_CTRL_IA_CONFIG_ADDR    8'h10
`define SA_CTRL_IA_STATUS_ADDR    8'h14
`define SA_CTRL_IA_RDATA_ADDR     8'h18
`define SA_SNAP_IA_CONFIG_ADDR    8'h1C
`define SA_SNAP_IA_STATUS_ADDR    8'h20
`define SA_SNAP_IA_RDATA_LO_ADDR  8'h24
`define SA_SNAP_IA_RDATA_HI_ADDR  8'h28
`define SA_COUNT_IA_CONFIG_ADDR   8'h2C
`define SA_COUNT_IA_STATUS_ADDR   8'h30
`define SA_COUNT_IA_RDATA_LO_ADDR 8'h34
`define SA_COUNT_IA_RDATA_HI_ADDR 8'h38

`endif

/* design/sa_pkg.sv */
`default_nettype none

`include "sa_defines.svh"

package sa_pkg;

  // one word travelling on the register ring.
  typedef struct packed {
    logic [`SA_RBUS_ADDR_BITS-1:0] addr;
    logic                          wr_strb;
    logic [`SA_RBUS_DATA_BITS-1:0] wr_data;
    logic                          rd_strb;
    logic [`SA_RBUS_DATA_BITS-1:0] rd_data;
    logic                          ack;
    logic                          err_ack;
  } rbus_ring_t;

  typedef struct packed {
    logic                           enable;
    logic [$clog2(`SA_N_EVENTS)-1:0] event_sel;
  } sa_ctrl_t;

  localparam sa_ctrl_t sa_ctrl_reset = '{enable: 1'b0, event_sel: '0};

  typedef enum logic [3:0] {
    IA_NOP         = 4'd0,
    IA_READ        = 4'd1,
    IA_WRITE       = 4'd2,
    IA_RESET_ENTRY = 4'd3,
    IA_RESET_ALL   = 4'd4
  } sa_ia_op_e;

  // op sits in bits 9:6, entry index in 5:0.
  typedef struct packed {
    sa_ia_op_e               op;
    logic [`SA_IDX_BITS-1:0] addr;
  } sa_ia_config_t;

  typedef enum logic [2:0] {
    IA_READY  = 3'd0,
    IA_ERROR  = 3'd1,
    IA_BAD_OP = 3'd2
  } sa_ia_code_e;

  // code sits in bits 8:6, entry index in 5:0.
  typedef struct packed {
    sa_ia_code_e             code;
    logic [`SA_IDX_BITS-1:0] addr;
  } sa_ia_status_t;

endpackage

`default_nettype wire

/* design/sa_rbus_node.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_rbus_node (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  sa_pkg::rbus_ring_t            rbus_ring_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_start_addr_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_end_addr_i,
  input  logic [`SA_RBUS_DATA_BITS-1:0] locl_rd_data_i,
  input  logic                          locl_ack_i,
  input  logic                          locl_err_ack_i,
  output sa_pkg::rbus_ring_t            rbus_ring_o,
  output logic [`SA_LOCL_ADDR_BITS-1:0] locl_addr_o,
  output logic                          locl_wr_strb_o,
  output logic [`SA_RBUS_DATA_BITS-1:0] locl_wr_data_o,
  output logic                          locl_rd_strb_o
);

  logic                          in_window;
  logic                          claim;
  logic [`SA_RBUS_ADDR_BITS-1:0] offset;
  sa_pkg::rbus_ring_t            ring_next;
  logic                          rsp_ack_q;
  logic                          rsp_err_q;
  logic [`SA_RBUS_DATA_BITS-1:0] rsp_data_q;

  assign in_window = (rbus_ring_i.addr >= cfg_start_addr_i) &&
                     (rbus_ring_i.addr <= cfg_end_addr_i);
  assign claim     = in_window && (rbus_ring_i.wr_strb || rbus_ring_i.rd_strb);
  assign offset    = rbus_ring_i.addr - cfg_start_addr_i;

  always_comb begin
    ring_next = rbus_ring_i;
    if (claim) begin
      ring_next.wr_strb = 1'b0;
      ring_next.rd_strb = 1'b0;
    end
    // local response rides on whatever word passes by.
    if (rsp_ack_q || rsp_err_q) begin
      ring_next.ack     = rsp_ack_q;
      ring_next.err_ack = rsp_err_q;
      ring_next.rd_data = rsp_data_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rbus_ring_o    <= '0;
      locl_wr_strb_o <= 1'b0;
      locl_rd_strb_o <= 1'b0;
      rsp_ack_q      <= 1'b0;
      rsp_err_q      <= 1'b0;
    end else begin
      rbus_ring_o    <= ring_next;
      locl_wr_strb_o <= claim && rbus_ring_i.wr_strb;
      locl_rd_strb_o <= claim && rbus_ring_i.rd_strb;
      rsp_ack_q      <= locl_ack_i;
      rsp_err_q      <= locl_err_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin
    locl_addr_o    <= offset[`SA_LOCL_ADDR_BITS-1:0];
    locl_wr_data_o <= rbus_ring_i.wr_data;
    rsp_data_q     <= locl_rd_data_i;
  end

  a_ack_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(rbus_ring_o.ack && rbus_ring_o.err_ack));

  // every local strobe is answered on the following cycle.
  a_locl_answer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (locl_wr_strb_o || locl_rd_strb_o) |=> (locl_ack_i || locl_err_ack_i));

endmodule

`default_nettype wire

/* design/sa_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [`SA_LOCL_ADDR_BITS-1:0] locl_addr_i,
  input  logic                          locl_wr_strb_i,
  input  logic [`SA_RBUS_DATA_BITS-1:0] locl_wr_data_i,
  input  logic                          locl_rd_strb_i,
  input  sa_pkg::sa_ctrl_t              ctrl_rdata_i,
  input  sa_pkg::sa_ia_status_t         ctrl_status_i,
  input  sa_pkg::sa_ia_status_t         snap_status_i,
  input  sa_pkg::sa_ia_status_t         count_status_i,
  input  logic [`SA_COUNT_BITS-1:0]     snap_rdata_i,
  input  logic [`SA_COUNT_BITS-1:0]     count_rdata_i,
  output logic [`SA_RBUS_DATA_BITS-1:0] locl_rd_data_o,
  output logic                          locl_ack_o,
  output logic                          locl_err_ack_o,
  output logic                          snap_o,
  output logic                          clear_live_o,
  output sa_pkg::sa_ctrl_t              ctrl_wdata_o,
  output sa_pkg::sa_ia_config_t         ctrl_cmd_o,
  output sa_pkg::sa_ia_config_t         snap_cmd_o,
  output sa_pkg::sa_ia_config_t         count_cmd_o,
  output logic                          ctrl_cmd_stb_o,
  output logic                          snap_cmd_stb_o,
  output logic                          count_cmd_stb_o
);

  localparam int DW = `SA_RBUS_DATA_BITS;
  localparam int CW = $bits(sa_pkg::sa_ctrl_t);
  localparam int FW = $bits(sa_pkg::sa_ia_config_t);

  logic [DW-1:0] spare_q;
  logic [DW-1:0] rd_mux;
  logic          hit;
  logic          ro;
  logic          err;
  logic          wr_en;
  logic          gctrl_wr;

  always_comb begin
    rd_mux = '0;
    hit    = 1'b1;
    ro     = 1'b0;
    case (locl_addr_i)
      `SA_REVISION_ADDR: begin
        rd_mux = DW'(`SA_REVISION);
        ro     = 1'b1;
      end
      `SA_SPARE_ADDR:          rd_mux = spare_q;
      `SA_GLOBAL_CTRL_ADDR:    rd_mux = '0;
      `SA_CTRL_IA_WDATA_ADDR:  rd_mux = DW'(ctrl_wdata_o);
      `SA_CTRL_IA_CONFIG_ADDR: rd_mux = DW'(ctrl_cmd_o);
      `SA_CTRL_IA_STATUS_ADDR: begin
        rd_mux = DW'(ctrl_status_i);
        ro     = 1'b1;
      end
      `SA_CTRL_IA_RDATA_ADDR: begin
        rd_mux = DW'(ctrl_rdata_i);
        ro     = 1'b1;
      end
      `SA_SNAP_IA_CONFIG_ADDR: rd_mux = DW'(snap_cmd_o);
      `SA_SNAP_IA_STATUS_ADDR: begin
        rd_mux = DW'(snap_status_i);
        ro     = 1'b1;
      end
      `SA_SNAP_IA_RDATA_LO_ADDR: begin
        rd_mux = snap_rdata_i[DW-1:0];
        ro     = 1'b1;
      end
      `SA_SNAP_IA_RDATA_HI_ADDR: begin
        rd_mux = DW'(snap_rdata_i[`SA_COUNT_BITS-1:DW]);
        ro     = 1'b1;
      end
      `SA_COUNT_IA_CONFIG_ADDR: rd_mux = DW'(count_cmd_o);
      `SA_COUNT_IA_STATUS_ADDR: begin
        rd_mux = DW'(count_status_i);
        ro     = 1'b1;
      end
      `SA_COUNT_IA_RDATA_LO_ADDR: begin
        rd_mux = count_rdata_i[DW-1:0];
        ro     = 1'b1;
      end
      `SA_COUNT_IA_RDATA_HI_ADDR: begin
        rd_mux = DW'(count_rdata_i[`SA_COUNT_BITS-1:DW]);
        ro     = 1'b1;
      end
      default: hit = 1'b0;
    endcase
  end

  assign err      = (locl_wr_strb_i && (!hit || ro)) || (locl_rd_strb_i && !hit);
  assign wr_en    = locl_wr_strb_i && hit && !ro;
  assign gctrl_wr = wr_en && (locl_addr_i == `SA_GLOBAL_CTRL_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locl_ack_o      <= 1'b0;
      locl_err_ack_o  <= 1'b0;
      snap_o          <= 1'b0;
      clear_live_o    <= 1'b0;
      ctrl_cmd_stb_o  <= 1'b0;
      snap_cmd_stb_o  <= 1'b0;
      count_cmd_stb_o <= 1'b0;
      spare_q         <= '0;
      ctrl_wdata_o    <= sa_pkg::sa_ctrl_reset;
      ctrl_cmd_o      <= '0;
      snap_cmd_o      <= '0;
      count_cmd_o     <= '0;
    end else begin
      locl_ack_o      <= (locl_wr_strb_i || locl_rd_strb_i) && !err;
      locl_err_ack_o  <= err;
      // global control self-clears, so it only ever pulses.
      snap_o          <= gctrl_wr && locl_wr_data_i[0];
      clear_live_o    <= gctrl_wr && locl_wr_data_i[1];
      ctrl_cmd_stb_o  <= wr_en && (locl_addr_i == `SA_CTRL_IA_CONFIG_ADDR);
      snap_cmd_stb_o  <= wr_en && (locl_addr_i == `SA_SNAP_IA_CONFIG_ADDR);
      count_cmd_stb_o <= wr_en && (locl_addr_i == `SA_COUNT_IA_CONFIG_ADDR);
      if (wr_en) begin
        case (locl_addr_i)
          `SA_SPARE_ADDR:           spare_q <= locl_wr_data_i;
          `SA_CTRL_IA_WDATA_ADDR:   ctrl_wdata_o <= sa_pkg::sa_ctrl_t'(locl_wr_data_i[CW-1:0]);
          `SA_CTRL_IA_CONFIG_ADDR:  ctrl_cmd_o <= sa_pkg::sa_ia_config_t'(locl_wr_data_i[FW-1:0]);
          `SA_SNAP_IA_CONFIG_ADDR:  snap_cmd_o <= sa_pkg::sa_ia_config_t'(locl_wr_data_i[FW-1:0]);
          `SA_COUNT_IA_CONFIG_ADDR: count_cmd_o <= sa_pkg::sa_ia_config_t'(locl_wr_data_i[FW-1:0]);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    locl_rd_data_o <= locl_rd_strb_i ? rd_mux : '0;
  end

  a_one_cmd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ctrl_cmd_stb_o, snap_cmd_stb_o, count_cmd_stb_o}));

endmodule

`default_nettype wire

/* design/sa_ctrl_indirect.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_ctrl_indirect (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     cmd_stb_i,
  input  sa_pkg::sa_ia_config_t                    cmd_i,
  input  sa_pkg::sa_ctrl_t                         wdata_i,
  output sa_pkg::sa_ia_status_t                    status_o,
  output sa_pkg::sa_ctrl_t                         rdata_o,
  output sa_pkg::sa_ctrl_t [`SA_N_CHANNELS-1:0]    ctrl_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_o <= '{code: sa_pkg::IA_READY, addr: '0};
      for (int i = 0; i < `SA_N_CHANNELS; i++) begin
        ctrl_o[i] <= sa_pkg::sa_ctrl_reset;
      end
    end else if (cmd_stb_i) begin
      status_o.addr <= cmd_i.addr;
      status_o.code <= sa_pkg::IA_READY;
      case (cmd_i.op)
        sa_pkg::IA_NOP,
        sa_pkg::IA_READ:        ;
        sa_pkg::IA_WRITE:       ctrl_o[cmd_i.addr] <= wdata_i;
        sa_pkg::IA_RESET_ENTRY: ctrl_o[cmd_i.addr] <= sa_pkg::sa_ctrl_reset;
        sa_pkg::IA_RESET_ALL: begin
          for (int i = 0; i < `SA_N_CHANNELS; i++) begin
            ctrl_o[i] <= sa_pkg::sa_ctrl_reset;
          end
        end
        default: status_o.code <= sa_pkg::IA_BAD_OP;
      endcase
    end
  end

  // read data is taken before any write in the same command.
  always_ff @(posedge clk_i) begin
    if (cmd_stb_i && (cmd_i.op == sa_pkg::IA_READ)) begin
      rdata_o <= ctrl_o[cmd_i.addr];
    end
  end

  // command and write data are fully driven when a command fires.
  a_cmd_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_stb_i |-> !$isunknown({cmd_i, wdata_i}));

endmodule

`default_nettype wire

/* design/sa_ro_indirect.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_ro_indirect (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         cmd_stb_i,
  input  sa_pkg::sa_ia_config_t                        cmd_i,
  input  logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] bank_i,
  output sa_pkg::sa_ia_status_t                        status_o,
  output logic [`SA_COUNT_BITS-1:0]                    rdata_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_o <= '{code: sa_pkg::IA_READY, addr: '0};
    end else if (cmd_stb_i) begin
      status_o.addr <= cmd_i.addr;
      // bank is read-only, only nop and read are legal.
      if ((cmd_i.op == sa_pkg::IA_NOP) || (cmd_i.op == sa_pkg::IA_READ)) begin
        status_o.code <= sa_pkg::IA_READY;
      end else begin
        status_o.code <= sa_pkg::IA_BAD_OP;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_stb_i && (cmd_i.op == sa_pkg::IA_READ)) begin
      rdata_o <= bank_i[cmd_i.addr];
    end
  end

endmodule

`default_nettype wire

/* design/sa_counter_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_counter_bank (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic [`SA_N_EVENTS-1:0]                      events_i,
  input  sa_pkg::sa_ctrl_t [`SA_N_CHANNELS-1:0]        ctrl_i,
  input  logic                                         snap_i,
  input  logic                                         clear_live_i,
  output logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] count_o,
  output logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] snapshot_o
);

  logic [`SA_N_CHANNELS-1:0] hit;

  always_comb begin
    for (int i = 0; i < `SA_N_CHANNELS; i++) begin
      hit[i] = ctrl_i[i].enable && events_i[ctrl_i[i].event_sel];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_o    <= '0;
      snapshot_o <= '0;
    end else begin
      // snapshot sees the values from before this edge's update.
      if (snap_i) begin
        snapshot_o <= count_o;
      end
      for (int i = 0; i < `SA_N_CHANNELS; i++) begin
        if (clear_live_i) begin
          count_o[i] <= '0;
        end else if (hit[i]) begin
          count_o[i] <= count_o[i] + 1'b1;
        end
      end
    end
  end

  for (genvar g = 0; g < `SA_N_CHANNELS; g++) begin : g_chk
    a_idle_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (!ctrl_i[g].enable && !clear_live_i) |=> $stable(count_o[g]));
  end

endmodule

`default_nettype wire

/* design/sa_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_regfile (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  sa_pkg::rbus_ring_t                           rbus_ring_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0]                cfg_start_addr_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0]                cfg_end_addr_i,
  input  logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] snapshot_i,
  input  logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] count_i,
  output sa_pkg::rbus_ring_t                           rbus_ring_o,
  output logic                                         snap_o,
  output logic                                         clear_live_o,
  output sa_pkg::sa_ctrl_t [`SA_N_CHANNELS-1:0]        ctrl_o
);

  logic [`SA_LOCL_ADDR_BITS-1:0] locl_addr;
  logic                          locl_wr_strb;
  logic [`SA_RBUS_DATA_BITS-1:0] locl_wr_data;
  logic                          locl_rd_strb;
  logic [`SA_RBUS_DATA_BITS-1:0] locl_rd_data;
  logic                          locl_ack;
  logic                          locl_err_ack;

  sa_pkg::sa_ctrl_t              ctrl_wdata;
  sa_pkg::sa_ctrl_t              ctrl_rdata;
  sa_pkg::sa_ia_config_t         ctrl_cmd;
  sa_pkg::sa_ia_config_t         snap_cmd;
  sa_pkg::sa_ia_config_t         count_cmd;
  sa_pkg::sa_ia_status_t         ctrl_status;
  sa_pkg::sa_ia_status_t         snap_status;
  sa_pkg::sa_ia_status_t         count_status;
  logic                          ctrl_cmd_stb;
  logic                          snap_cmd_stb;
  logic                          count_cmd_stb;
  logic [`SA_COUNT_BITS-1:0]     snap_rdata;
  logic [`SA_COUNT_BITS-1:0]     count_rdata;

  sa_rbus_node u_node (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .rbus_ring_i      (rbus_ring_i),
    .cfg_start_addr_i (cfg_start_addr_i),
    .cfg_end_addr_i   (cfg_end_addr_i),
    .locl_rd_data_i   (locl_rd_data),
    .locl_ack_i       (locl_ack),
    .locl_err_ack_i   (locl_err_ack),
    .rbus_ring_o      (rbus_ring_o),
    .locl_addr_o      (locl_addr),
    .locl_wr_strb_o   (locl_wr_strb),
    .locl_wr_data_o   (locl_wr_data),
    .locl_rd_strb_o   (locl_rd_strb)
  );

  sa_regs u_regs (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .locl_addr_i     (locl_addr),
    .locl_wr_strb_i  (locl_wr_strb),
    .locl_wr_data_i  (locl_wr_data),
    .locl_rd_strb_i  (locl_rd_strb),
    .ctrl_rdata_i    (ctrl_rdata),
    .ctrl_status_i   (ctrl_status),
    .snap_status_i   (snap_status),
    .count_status_i  (count_status),
    .snap_rdata_i    (snap_rdata),
    .count_rdata_i   (count_rdata),
    .locl_rd_data_o  (locl_rd_data),
    .locl_ack_o      (locl_ack),
    .locl_err_ack_o  (locl_err_ack),
    .snap_o          (snap_o),
    .clear_live_o    (clear_live_o),
    .ctrl_wdata_o    (ctrl_wdata),
    .ctrl_cmd_o      (ctrl_cmd),
    .snap_cmd_o      (snap_cmd),
    .count_cmd_o     (count_cmd),
    .ctrl_cmd_stb_o  (ctrl_cmd_stb),
    .snap_cmd_stb_o  (snap_cmd_stb),
    .count_cmd_stb_o (count_cmd_stb)
  );

  sa_ctrl_indirect u_ctrl_ia (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cmd_stb_i (ctrl_cmd_stb),
    .cmd_i     (ctrl_cmd),
    .wdata_i   (ctrl_wdata),
    .status_o  (ctrl_status),
    .rdata_o   (ctrl_rdata),
    .ctrl_o    (ctrl_o)
  );

  sa_ro_indirect u_snap_ia (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cmd_stb_i (snap_cmd_stb),
    .cmd_i     (snap_cmd),
    .bank_i    (snapshot_i),
    .status_o  (snap_status),
    .rdata_o   (snap_rdata)
  );

  sa_ro_indirect u_count_ia (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cmd_stb_i (count_cmd_stb),
    .cmd_i     (count_cmd),
    .bank_i    (count_i),
    .status_o  (count_status),
    .rdata_o   (count_rdata)
  );

endmodule

`default_nettype wire

/* design/sa_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  sa_pkg::rbus_ring_t            rbus_ring_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_start_addr_i,
  input  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_end_addr_i,
  input  logic [`SA_N_EVENTS-1:0]       events_i,
  output sa_pkg::rbus_ring_t            rbus_ring_o
);

  logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] snapshot;
  logic [`SA_N_CHANNELS-1:0][`SA_COUNT_BITS-1:0] count;
  sa_pkg::sa_ctrl_t [`SA_N_CHANNELS-1:0]         ctrl;
  logic                                          snap;
  logic                                          clear_live;

  sa_regfile u_regfile (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .rbus_ring_i      (rbus_ring_i),
    .cfg_start_addr_i (cfg_start_addr_i),
    .cfg_end_addr_i   (cfg_end_addr_i),
    .snapshot_i       (snapshot),
    .count_i          (count),
    .rbus_ring_o      (rbus_ring_o),
    .snap_o           (snap),
    .clear_live_o     (clear_live),
    .ctrl_o           (ctrl)
  );

  sa_counter_bank u_counter_bank (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .events_i     (events_i),
    .ctrl_i       (ctrl),
    .snap_i       (snap),
    .clear_live_i (clear_live),
    .count_o      (count),
    .snapshot_o   (snapshot)
  );

endmodule

`default_nettype wire

/* verification/sa_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sa_defines.svh"

module sa_tb;

  localparam int ACK_TIMEOUT = 16;
  localparam int SW = $bits(sa_pkg::sa_ia_status_t);

  logic                          clk_i;
  logic                          arst_n_i;
  sa_pkg::rbus_ring_t            rbus_ring_i;
  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_start_addr_i;
  logic [`SA_RBUS_ADDR_BITS-1:0] cfg_end_addr_i;
  logic [`SA_N_EVENTS-1:0]       events_i;
  sa_pkg::rbus_ring_t            rbus_ring_o;

  sa_top u_dut (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .rbus_ring_i      (rbus_ring_i),
    .cfg_start_addr_i (cfg_start_addr_i),
    .cfg_end_addr_i   (cfg_end_addr_i),
    .events_i         (events_i),
    .rbus_ring_o      (rbus_ring_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_ring(input string name, input sa_pkg::rbus_ring_t got,
                            input sa_pkg::rbus_ring_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s = 0x%h, expected 0x%h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input sa_pkg::sa_ia_status_t got,
                              input sa_pkg::sa_ia_status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s = code %0d addr %0d, expected code %0d addr %0d",
                          $time, name, got.code, got.addr, exp.code, exp.addr));
    end
  endtask

  // one request on the ring, then wait for its ack or err_ack.
  task automatic ring_access(input logic [15:0] addr, input logic is_wr,
                             input logic [31:0] wdata, output sa_pkg::rbus_ring_t rsp);
    sa_pkg::rbus_ring_t req;
    sa_pkg::rbus_ring_t stripped;
    int                 waited;
    req         = '0;
    req.addr    = addr;
    req.wr_strb = is_wr;
    req.rd_strb = !is_wr;
    req.wr_data = wdata;
    @(posedge clk_i);
    rbus_ring_i <= req;
    @(posedge clk_i);
    rbus_ring_i <= '0;
    waited = 0;
    @(negedge clk_i);
    // claimed word leaves the node without its strobes.
    stripped         = req;
    stripped.wr_strb = 1'b0;
    stripped.rd_strb = 1'b0;
    check_ring("rbus_ring_o", rbus_ring_o, stripped);
    while (!(rbus_ring_o.ack || rbus_ring_o.err_ack)) begin
      waited++;
      if (waited > ACK_TIMEOUT) begin
        abort_run($sformatf("no response on the ring for address 0x%04h", addr));
      end
      @(negedge clk_i);
    end
    rsp = rbus_ring_o;
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [31:0] wdata, input logic err);
    sa_pkg::rbus_ring_t rsp;
    ring_access(addr, 1'b1, wdata, rsp);
    check_data("rbus_ring_o.{err_ack,ack}", 32'({rsp.err_ack, rsp.ack}), err ? 32'd2 : 32'd1);
  endtask

  task automatic read_reg(input logic [15:0] addr, input logic err, input logic [31:0] exp);
    sa_pkg::rbus_ring_t rsp;
    logic [7:0]         offset;
    ring_access(addr, 1'b0, 32'd0, rsp);
    check_data("rbus_ring_o.{err_ack,ack}", 32'({rsp.err_ack, rsp.ack}), err ? 32'd2 : 32'd1);
    offset = 8'(addr - cfg_start_addr_i);
    if (!err) begin
      if (offset == `SA_CTRL_IA_STATUS_ADDR || offset == `SA_SNAP_IA_STATUS_ADDR ||
          offset == `SA_COUNT_IA_STATUS_ADDR) begin
        check_status("rbus_ring_o.rd_data", sa_pkg::sa_ia_status_t'(rsp.rd_data[SW-1:0]),
                     sa_pkg::sa_ia_status_t'(exp[SW-1:0]));
      end else begin
        check_data("rbus_ring_o.rd_data", rsp.rd_data, exp);
      end
    end
  endtask

  // out-of-window word must come back unchanged one cycle later.
  task automatic pass_through(input logic [15:0] addr, input logic is_wr);
    sa_pkg::rbus_ring_t word;
    word         = '0;
    word.addr    = addr;
    word.wr_strb = is_wr;
    word.rd_strb = !is_wr;
    word.wr_data = $urandom;
    word.rd_data = $urandom;
    @(posedge clk_i);
    rbus_ring_i <= word;
    @(negedge clk_i);
    check_ring("rbus_ring_o", rbus_ring_o, '0);
    @(posedge clk_i);
    rbus_ring_i <= '0;
    @(negedge clk_i);
    check_ring("rbus_ring_o", rbus_ring_o, word);
  endtask

  task automatic drive_events(input logic [15:0] mask, input int cycles);
    @(posedge clk_i);
    events_i <= mask;
    repeat (cycles) @(posedge clk_i);
    events_i <= '0;
  endtask

  initial begin
    string       line;
    string       op;
    int          fd;
    int          n_fields;
    int          n_ops;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    rbus_ring_i      = '0;
    events_i         = '0;
    cfg_start_addr_i = 16'h1000;
    cfg_end_addr_i   = 16'h10ff;
    void'($urandom(32'hc55296d6));
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    fd = $fopen("verification/sa_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/sa_cases.txt");
    end
    n_ops = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n_fields = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
      if (n_fields <= 0) continue;
      if (n_fields != 4) begin
        abort_run($sformatf("malformed line in cases file: %s", line));
      end
      if (op == "write") begin
        write_reg(addr, data, exp[0]);
      end else if (op == "read") begin
        read_reg(addr, data[0], exp);
      end else if (op == "events") begin
        drive_events(addr, int'(data));
      end else if (op == "passthru") begin
        pass_through(addr, data[0]);
      end else begin
        abort_run($sformatf("unknown operation %s in cases file", op));
      end
      n_ops++;
    end
    $fclose(fd);
    if (n_ops == 0) begin
      abort_run("cases file holds no operations");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/sa_cases.txt */
# op addr data expected, hex. write: data, expected 1 for err_ack. read: data 1 for err_ack.
# events: addr is the line mask, data the cycle count. passthru: data 1 for write.
read 1000 0 0000002a
read 1014 0 00000000
write 1004 deadbeef 0
read 1004 0 deadbeef
read 1040 1 0
write 1000 12345678 1
passthru 2000 1 0
passthru 0ffc 0 0
passthru 1100 1 0
write 100c 17 0
write 1010 8c 0
read 1014 0 0c
write 1010 4c 0
read 1018 0 17
write 1010 cc 0
write 1010 4c 0
read 1018 0 0
read 1014 0 0c
write 100c 1b 0
write 1010 a5 0
events f7ff 5 0
events 0800 d 0
write 1008 1 0
read 1008 0 0
write 101c 65 0
read 1020 0 25
read 1024 0 d
read 1028 0 0
write 102c 65 0
read 1034 0 d
read 1038 0 0
write 1008 2 0
write 102c 65 0
read 1034 0 0
write 101c 65 0
read 1024 0 d
write 102c a5 0
read 1030 0 a5

/* verilog.f */
+incdir+design
design/sa_pkg.sv
design/sa_rbus_node.sv
design/sa_regs.sv
design/sa_ctrl_indirect.sv
design/sa_ro_indirect.sv
design/sa_counter_bank.sv
design/sa_regfile.sv
design/sa_top.sv
verification/sa_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module sa_tb -f verilog.f -o sa_sim; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/sa_sim)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
